//--- hdl/cpu_pkg.sv
`default_nettype none
// ----------------------------------------
// widths, bus slots, opcodes and the microinstruction
// layout shared by the core; modules import cpu_pkg::*
// ----------------------------------------
package cpu_pkg;

    localparam int word_w    = 16;   // bus and data width
    localparam int addr_w    = 8;    // pc, ar and memory address
    localparam int mem_depth = 256;
    localparam int ustep_w   = 3;    // up to 8 micro-steps

    // bus sources, decoded only while eo is high
    localparam logic [2:0] out_pc   = 3'd0;
    localparam logic [2:0] out_irh  = 3'd1;
    localparam logic [2:0] out_irl  = 3'd2;
    localparam logic [2:0] out_mem  = 3'd3;
    localparam logic [2:0] out_dev  = 3'd6;
    localparam logic [2:0] out_none = 3'd7;  // spare slot, bus reads 0

    // bus loaders
    localparam logic [2:0] in_none = 3'd0;   // nobody loads
    localparam logic [2:0] in_ar   = 3'd1;
    localparam logic [2:0] in_ir   = 3'd2;
    localparam logic [2:0] in_mem  = 3'd3;
    localparam logic [2:0] in_x    = 3'd4;
    localparam logic [2:0] in_y    = 3'd5;
    localparam logic [2:0] in_dev  = 3'd6;

    // opcodes in ir[15:12], operand in ir[7:0]
    localparam logic [3:0] op_ldx = 4'h1;
    localparam logic [3:0] op_ldy = 4'h2;
    localparam logic [3:0] op_alu = 4'h3;   // ir[5:0] = ex nx ey ny f no
    localparam logic [3:0] op_out = 4'h4;
    localparam logic [3:0] op_in  = 4'h5;
    localparam logic [3:0] op_jmp = 4'h6;   // ir[11:8] = c z gt lt, 0 = always
    localparam logic [3:0] op_hlt = 4'h7;

    // flag bits
    localparam int flg_c = 2;
    localparam int flg_z = 1;
    localparam int flg_n = 0;

    // apb requester states
    localparam logic [1:0] apb_idle   = 2'd0;
    localparam logic [1:0] apb_setup  = 2'd1;
    localparam logic [1:0] apb_access = 2'd2;

    // one word, two readings; eo low selects the alu view
    typedef union packed {
        struct packed {
            logic       eo;        // active low, alu drives bus
            logic [2:0] out_sel;
            logic       rt;        // pc retarget
            logic       pp;        // pc + 1
            logic       spare;
            logic [2:0] in_sel;
            logic       jc, jz, jgt, jlt;
            logic [1:0] spare_lo;
        } bus_v;
        struct packed {
            logic       eo;
            logic       ex, nx, ey, ny, f, no;
            logic [2:0] in_sel;
            logic [3:0] jmp;
            logic [1:0] spare_lo;
        } alu_v;
    } uinstr_t;

endpackage
`default_nettype wire

//--- hdl/microcode_sequencer.sv
`default_nettype none
// ----------------------------------------
// fetch/execute micro-step counter, instruction register
// and microcode table; idles until run, stops on op_hlt
// ----------------------------------------
module microcode_sequencer (
    input  wire                         clk, arst_n, run, stall,
    input  wire  [cpu_pkg::word_w-1:0]  bus,
    input  wire                         ii_n,
    output cpu_pkg::uinstr_t            uinstr,
    output logic [cpu_pkg::word_w-1:0]  ir_word,
    output logic                        halted
);
    import cpu_pkg::*;

    logic [ustep_w-1:0] step;
    logic [3:0]         opcode;
    logic               active;

    function automatic uinstr_t idle_uop();
        uinstr_t u;
        u = '0;
        u.bus_v.eo      = 1'b1;      // alu off the bus
        u.bus_v.out_sel = out_none;
        u.bus_v.in_sel  = in_none;
        return u;
    endfunction

    function automatic logic [ustep_w-1:0] last_step(input logic [3:0] op);
        return (op == op_out || op == op_in) ? ustep_w'(3) : ustep_w'(2);
    endfunction

    function automatic uinstr_t ucode(input logic [ustep_w-1:0] st,
                                      input logic [word_w-1:0] ir);
        uinstr_t u;
        u = idle_uop();
        case (st)
            3'd0: begin                      // fetch 1, pc -> ar
                u.bus_v.out_sel = out_pc;
                u.bus_v.in_sel  = in_ar;
            end
            3'd1: begin                      // fetch 2, mem -> ir
                u.bus_v.out_sel = out_mem;
                u.bus_v.in_sel  = in_ir;
                u.bus_v.pp      = 1'b1;
            end
            3'd2: begin
                u.bus_v.out_sel = out_irl;   // operand byte
                case (ir[15:12])
                    op_ldx: u.bus_v.in_sel = in_x;
                    op_ldy: u.bus_v.in_sel = in_y;
                    op_out, op_in: u.bus_v.in_sel = in_ar;   // device address first
                    op_alu: begin
                        u.bus_v.eo = 1'b0;   // alu view from here on
                        {u.alu_v.ex, u.alu_v.nx, u.alu_v.ey,
                         u.alu_v.ny, u.alu_v.f, u.alu_v.no} = ir[5:0];
                        u.alu_v.in_sel = in_x;
                    end
                    op_jmp: begin
                        {u.bus_v.jc, u.bus_v.jz, u.bus_v.jgt, u.bus_v.jlt} = ir[11:8];
                        u.bus_v.rt = (ir[11:8] == 4'b0000);   // unconditional
                    end
                    default: u.bus_v.out_sel = out_none;  // hlt, unused codes
                endcase
            end
            3'd3: begin
                if (ir[15:12] == op_out) begin
                    u.bus_v.in_sel = in_dev;         // x goes out as pwdata
                end else if (ir[15:12] == op_in) begin
                    u.bus_v.out_sel = out_dev;
                    u.bus_v.in_sel  = in_x;
                end
            end
            default: ;
        endcase
        return u;
    endfunction

    assign opcode = ir_word[15:12];
    assign active = run & ~halted;
    assign uinstr = active ? ucode(step, ir_word) : idle_uop();

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            step    <= '0;
            halted  <= 1'b0;
            ir_word <= '0;
        end else begin
            if (!ii_n && !stall)
                ir_word <= bus;
            if (active && !stall) begin      // hold step through apb waits
                if (step == last_step(opcode)) begin
                    step <= '0;
                    if (opcode == op_hlt)
                        halted <= 1'b1;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // steps 0/1 are below any last step, later ones use the fresh ir
    assert property (@(posedge clk) disable iff (!arst_n) step <= last_step(opcode))
        else $error("sequencer: step %0d past end of opcode %h", step, opcode);

endmodule
`default_nettype wire

//--- hdl/control_decode.sv
`default_nettype none
// ----------------------------------------
// microinstruction to bus strobes, alu bits and jump
// enables; purely combinational
// ----------------------------------------
module control_decode (
    input  wire cpu_pkg::uinstr_t uinstr,
    output logic       po_n, ioh_n, iol_n, mo, do_rd, rt, pp,
    output logic       eo_n, ai_n, ii_n, mi, xi_n, yi_n, di_wr,
    output logic [5:0] alu_ctl,
    output logic [3:0] jmp_en
);
    import cpu_pkg::*;

    logic [7:0] out_dec_n;   // active-low 3-to-8, sources
    logic [7:0] in_dec_n;    // active-low 3-to-8, loaders

    assign eo_n = uinstr.bus_v.eo;

    always_comb begin
        out_dec_n = '1;
        in_dec_n  = '1;
        if (eo_n)                            // source decode enabled by eo
            out_dec_n[uinstr.bus_v.out_sel] = 1'b0;
        in_dec_n[uinstr.bus_v.in_sel] = 1'b0;  // slot 0 drives nothing
    end

    assign po_n  = out_dec_n[out_pc];
    assign ioh_n = out_dec_n[out_irh];   // opcode byte
    assign iol_n = out_dec_n[out_irl];   // operand byte
    assign mo    = ~out_dec_n[out_mem];
    assign do_rd = ~out_dec_n[out_dev];

    assign ai_n  = in_dec_n[in_ar];
    assign ii_n  = in_dec_n[in_ir];
    assign mi    = ~in_dec_n[in_mem];
    assign xi_n  = in_dec_n[in_x];
    assign yi_n  = in_dec_n[in_y];
    assign di_wr = ~in_dec_n[in_dev];

    // alu bits share rt/pp positions, so those only count with eo high
    assign rt = eo_n & uinstr.bus_v.rt;
    assign pp = eo_n & uinstr.bus_v.pp;

    assign alu_ctl = {uinstr.alu_v.ex, uinstr.alu_v.nx, uinstr.alu_v.ey,
                      uinstr.alu_v.ny, uinstr.alu_v.f, uinstr.alu_v.no};
    assign jmp_en  = {uinstr.bus_v.jc, uinstr.bus_v.jz,
                      uinstr.bus_v.jgt, uinstr.bus_v.jlt};

endmodule
`default_nettype wire

//--- hdl/alu.sv
`default_nettype none
// ----------------------------------------
// x/y alu, zero/negate each input, add or and,
// optional output invert; flags latch while it drives
// ----------------------------------------
module alu (
    input  wire                         clk, arst_n,
    input  wire  [cpu_pkg::word_w-1:0]  x, y,
    input  wire  [5:0]                  alu_ctl,
    input  wire                         eo_n,
    output logic [cpu_pkg::word_w-1:0]  result,
    output logic [2:0]                  flags
);
    import cpu_pkg::*;

    logic              ex, nx, ey, ny, f, no;
    logic [word_w-1:0] xa, ya, core;
    logic              carry;

    assign {ex, nx, ey, ny, f, no} = alu_ctl;

    always_comb begin
        xa = ex ? '0 : x;
        ya = ey ? '0 : y;
        if (nx)
            xa = ~xa;
        if (ny)
            ya = ~ya;
        if (f) begin
            {carry, core} = xa + ya;   // 17-bit sum, carry on top
        end else begin
            carry = 1'b0;
            core  = xa & ya;
        end
        result = no ? ~core : core;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (!eo_n) begin
            flags[flg_c] <= carry;
            flags[flg_z] <= (result == '0);
            flags[flg_n] <= result[word_w-1];
        end
    end

endmodule
`default_nettype wire

//--- hdl/datapath.sv
`default_nettype none
// ----------------------------------------
// pc, ar, x, y and program memory around the single
// bus; memory is written through the load port while stopped
// ----------------------------------------
module datapath (
    input  wire                         clk, arst_n, run, stall,
    input  wire                         po_n, ioh_n, iol_n, mo, do_rd, eo_n,
    input  wire                         ai_n, mi, xi_n, yi_n, rt, pp,
    input  wire  [cpu_pkg::word_w-1:0]  result,
    input  wire  [2:0]                  flags,
    input  wire  [3:0]                  jmp_en,
    input  wire  [cpu_pkg::word_w-1:0]  ir_word, dev_data,
    input  wire                         load_en,
    input  wire  [cpu_pkg::addr_w-1:0]  load_addr,
    input  wire  [cpu_pkg::word_w-1:0]  load_data,
    output logic [cpu_pkg::word_w-1:0]  bus, x, y,
    output logic [cpu_pkg::addr_w-1:0]  ar
);
    import cpu_pkg::*;

    logic [word_w-1:0] mem [mem_depth];
    logic [addr_w-1:0] pc;
    logic              jmp_taken;

    // bus mux, decode guarantees one source
    always_comb begin
        if (!po_n)
            bus = word_w'(pc);
        else if (!ioh_n)
            bus = word_w'(ir_word[15:8]);
        else if (!iol_n)
            bus = word_w'(ir_word[7:0]);
        else if (mo)
            bus = mem[ar];
        else if (do_rd)
            bus = dev_data;        // nonzero only on apb completion
        else if (!eo_n)
            bus = result;
        else
            bus = '0;
    end

    // gt = not zero and not negative, lt = negative
    assign jmp_taken = (jmp_en[3] & flags[flg_c])
                     | (jmp_en[2] & flags[flg_z])
                     | (jmp_en[1] & ~flags[flg_z] & ~flags[flg_n])
                     | (jmp_en[0] & flags[flg_n]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
            ar <= '0;
        end else if (!stall) begin
            if (rt || jmp_taken)
                pc <= bus[addr_w-1:0];   // target from operand byte
            else if (pp)
                pc <= pc + 1'b1;
            if (!ai_n)
                ar <= bus[addr_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (!xi_n)
                x <= bus;
            if (!yi_n)
                y <= bus;
        end
        if (load_en && !run)
            mem[load_addr] <= load_data;   // program load
        else if (mi && !stall)
            mem[ar] <= bus;
    end

    // program load only while the core is stopped
    assert property (@(posedge clk) disable iff (!arst_n) load_en |-> !run)
        else $error("datapath: load_en while running");

endmodule
`default_nettype wire

//--- hdl/apb_device_port.sv
`default_nettype none
// ----------------------------------------
// apb requester for device-in/out strobes; stalls the
// core until the access completes
// ----------------------------------------
module apb_device_port (
    input  wire                         clk, arst_n, do_rd, di_wr,
    input  wire  [cpu_pkg::addr_w-1:0]  ar,
    input  wire  [cpu_pkg::word_w-1:0]  x, prdata,
    input  wire                         pready,
    output logic                        psel, penable, pwrite,
    output logic [cpu_pkg::addr_w-1:0]  paddr,
    output logic [cpu_pkg::word_w-1:0]  pwdata, dev_data,
    output logic                        stall
);
    import cpu_pkg::*;

    logic [1:0] state;
    logic       req, done;

    assign req      = do_rd | di_wr;
    assign psel     = (state != apb_idle);
    assign penable  = (state == apb_access);
    assign done     = penable & pready;
    // request cycle, setup and waiting access cycles all hold the core
    assign stall    = ((state == apb_idle) & req) | (psel & ~done);
    assign dev_data = (done && !pwrite) ? prdata : '0;   // one cycle on the bus

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= apb_idle;
        end else begin
            case (state)
                apb_idle:   if (req) state <= apb_setup;
                apb_setup:  state <= apb_access;
                apb_access: if (pready) state <= apb_idle;
                default:    state <= apb_idle;
            endcase
        end
    end

    // transfer fields held from setup to completion
    always_ff @(posedge clk) begin
        if (state == apb_idle && req) begin
            paddr  <= ar;
            pwdata <= x;
            pwrite <= di_wr;
        end
    end

    // sequencer keeps its device strobe up until the access completes
    assert property (@(posedge clk) disable iff (!arst_n) psel |-> req)
        else $error("apb: request dropped during a transfer");

endmodule
`default_nettype wire

//--- hdl/cpu_core.sv
`default_nettype none
// ----------------------------------------
// core top; load memory with run low, then raise run
// and wait for halted
// ----------------------------------------
module cpu_core (
    input  wire                         clk, arst_n, run, load_en,
    input  wire  [cpu_pkg::addr_w-1:0]  load_addr,
    input  wire  [cpu_pkg::word_w-1:0]  load_data,
    output logic                        halted,
    output logic                        psel, penable, pwrite,
    output logic [cpu_pkg::addr_w-1:0]  paddr,
    output logic [cpu_pkg::word_w-1:0]  pwdata,
    input  wire  [cpu_pkg::word_w-1:0]  prdata,
    input  wire                         pready
);
    import cpu_pkg::*;

    uinstr_t           uinstr;
    logic [word_w-1:0] bus, ir_word, x, y, result, dev_data;
    logic [addr_w-1:0] ar;
    logic [2:0]        flags;
    logic [5:0]        alu_ctl;
    logic [3:0]        jmp_en;
    logic              stall;
    logic              po_n, ioh_n, iol_n, mo, do_rd, rt, pp;   // decoded strobes
    logic              eo_n, ai_n, ii_n, mi, xi_n, yi_n, di_wr;

    // port names match the nets above one to one
    microcode_sequencer sequencer_i (.*);

    control_decode decode_i (.*);

    alu alu_i (.*);

    datapath datapath_i (.*);

    apb_device_port dev_port_i (.*);

endmodule
`default_nettype wire

//--- test/cpu_core_tb.sv
`default_nettype none
// ----------------------------------------
// testbench for cpu_core; loads lfsr-built programs, runs each
// to halt and checks the apb writes against an isa model
// ----------------------------------------
module cpu_core_tb;
    import cpu_pkg::*;

    logic              clk = 1'b0;
    logic              arst_n, run, load_en, pready, halted, psel, penable, pwrite;
    logic [addr_w-1:0] load_addr, paddr;
    logic [word_w-1:0] load_data, prdata, pwdata;

    logic [15:0]       lfsr;
    logic [word_w-1:0] prog[$], exp_data[$], got_data[$], rd_q[$];
    logic [addr_w-1:0] exp_addr[$], got_addr[$];
    int                wait_q[$];          // wait states per transfer, model order
    int                cur_wait, wait_left, budget, run_cycles = 0;
    int                errors, checks, tests, failed;
    string             cur_test;

    cpu_core cpu_core_i (.*);

    always #2 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[14:0], lfsr[0]};   // one step per bit
        end
        return v;
    endfunction

    // returns {c, z, n, result}
    function automatic logic [18:0] alu_ref(input logic [15:0] a, b, input logic [5:0] c);
        logic [15:0] p, q, r;
        logic [16:0] s;
        p = c[5] ? 16'h0 : a;
        q = c[3] ? 16'h0 : b;
        p = c[4] ? ~p : p;
        q = c[2] ? ~q : q;
        s = c[1] ? ({1'b0, p} + {1'b0, q}) : {1'b0, p & q};   // and never carries
        r = c[0] ? ~s[15:0] : s[15:0];
        return {s[16], r == 16'h0, r[15], r};
    endfunction

    // cond bits c z gt lt against flags c z n
    function automatic logic jump_taken(input logic [3:0] cnd, input logic [2:0] fl);
        return (cnd[3] & fl[2]) | (cnd[2] & fl[1]) | (cnd[1] & ~fl[1] & ~fl[0])
             | (cnd[0] & fl[0]);
    endfunction

    function automatic void emit(input logic [3:0] op, cnd, input logic [7:0] arg);
        prog.push_back({op, cnd, arg});
    endfunction

    // isa model, fills expected writes, read data and wait states
    task automatic model_run(output int n_instr, output int wait_sum);
        logic [addr_w-1:0] pc;
        logic [word_w-1:0] mx, my, iw;
        logic [18:0]       res;
        logic [2:0]        fl;
        int                w;
        pc = '0;
        mx = '0;
        my = '0;
        fl = '0;                         // flags clear from reset
        n_instr = 0;
        wait_sum = 0;
        iw = '0;
        while (iw[15:12] != op_hlt && pc < prog.size()) begin
            iw = prog[pc];
            pc++;
            n_instr++;
            case (iw[15:12])
                op_ldx: mx = word_w'(iw[7:0]);
                op_ldy: my = word_w'(iw[7:0]);
                op_alu: begin
                    res = alu_ref(mx, my, iw[5:0]);
                    mx  = res[15:0];
                    fl  = res[18:16];
                end
                op_out, op_in: begin
                    w = int'(rand_bits(2));
                    wait_q.push_back(w);
                    wait_sum += w;
                    if (iw[15:12] == op_in) begin
                        mx = rand_bits(16);     // responder returns this
                        rd_q.push_back(mx);
                    end else begin
                        exp_addr.push_back(iw[7:0]);
                        exp_data.push_back(mx);
                    end
                end
                op_jmp: if (iw[11:8] == 4'h0 || jump_taken(iw[11:8], fl)) pc = iw[7:0];
                default: ;
            endcase
        end
    endtask

    task automatic check_word(input string what, input logic [word_w-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string what, input logic [addr_w-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // apb responder, wait states and read data come from the model queues
    always @(posedge clk) begin
        if (!arst_n) begin
            pready <= 1'b0;
        end else if (psel && !penable) begin
            cur_wait = (wait_q.size() > 0) ? wait_q.pop_front() : 0;
            wait_left <= cur_wait;
            pready    <= (cur_wait == 0);
            if (!pwrite && rd_q.size() > 0)
                prdata <= rd_q.pop_front();
        end else if (psel && !pready) begin
            wait_left <= wait_left - 1;
            pready    <= (wait_left == 1);
        end else if (psel) begin            // completing access
            pready <= 1'b0;
            if (pwrite) begin
                got_addr.push_back(paddr);
                got_data.push_back(pwdata);
            end
        end
    end

    // no transfer may start while stopped or after halt
    always @(posedge clk) begin
        if (arst_n && psel && (!run || halted)) begin
            $display("%s: apb select while the core is stopped or halted", cur_test);
            errors++;
        end
    end

    // watchdog, 40 cycles per executed instruction plus the wait states
    always @(posedge clk) begin
        if (!run) begin
            run_cycles <= 0;
        end else if (run_cycles > budget) begin
            $display("%s: core did not halt within %0d cycles", cur_test, budget);
            $display("Checks failed");
            $finish;
        end else begin
            run_cycles <= run_cycles + 1;
        end
    end

    task automatic run_program(input string name);
        int err0, n_instr, wait_sum, i;
        cur_test = name;
        err0 = errors;
        emit(op_hlt, 4'h0, 8'h00);
        model_run(n_instr, wait_sum);
        budget = 40 * n_instr + wait_sum;
        got_addr.delete();
        got_data.delete();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        if (psel || penable || halted) begin
            $display("%s: psel, penable or halted high after reset", name);
            errors++;
        end
        for (i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= addr_w'(i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        repeat (4) @(posedge clk);       // stopped core, monitor sees no apb
        run <= 1'b1;
        while (!halted) @(posedge clk);
        repeat (8) @(posedge clk);       // stray transfers after halt show up here
        if (got_addr.size() != exp_addr.size()) begin
            $display("Mismatch %s write count: expected %0d, actual %0d",
                     name, exp_addr.size(), got_addr.size());
            errors++;
        end
        for (i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
            check_addr($sformatf("write %0d paddr", i), exp_addr[i], got_addr[i]);
            check_word($sformatf("write %0d pwdata", i), exp_data[i], got_data[i]);
        end
        if (wait_q.size() != 0 || rd_q.size() != 0) begin
            $display("%s: fewer apb transfers than the model predicts", name);
            errors++;
        end
        run <= 1'b0;
        tests++;
        if (errors == err0) begin
            $display("test %s ok, %0d instructions, %0d writes", name, n_instr, got_addr.size());
        end else begin
            failed++;
            $display("test %s failed with %0d errors", name, errors - err0);
        end
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        wait_q.delete();
        rd_q.delete();
    endtask

    task automatic build_random(input int n);
        int i, last;
        last = n + 2;                    // index of the closing op_hlt
        emit(op_ldx, 4'h0, 8'(rand_bits(8)));
        emit(op_ldy, 4'h0, 8'(rand_bits(8)));
        for (i = 0; i < n; i++) begin
            case (int'(rand_bits(3)))
                0: emit(op_ldx, 4'h0, 8'(rand_bits(8)));
                1: emit(op_ldy, 4'h0, 8'(rand_bits(8)));
                2, 3: emit(op_alu, 4'h0, 8'(rand_bits(6)));
                4, 5: emit(op_out, 4'h0, 8'(rand_bits(8)));
                6: emit(op_in, 4'h0, 8'(rand_bits(8)));
                default: emit(op_jmp, 4'(rand_bits(4)),   // forward only
                              8'(prog.size() + 1 + int'(rand_bits(8)) % (last - prog.size())));
            endcase
        end
    endtask

    initial begin
        arst_n = 1'b0;
        run = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        prdata = '0;
        pready = 1'b0;
        lfsr = 16'd75;
        errors = 0;
        checks = 0;
        tests = 0;
        failed = 0;
        emit(op_ldx, 4'h0, 8'(rand_bits(8)));
        emit(op_out, 4'h0, 8'(rand_bits(8)));
        run_program("ldx_out");
        for (int i = 0; i < 6; i++) begin
            emit(op_ldx, 4'h0, 8'(rand_bits(8)));
            emit(op_ldy, 4'h0, 8'(rand_bits(8)));
            emit(op_alu, 4'h0, 8'(rand_bits(6)));
            emit(op_alu, 4'h0, 8'(rand_bits(6)));   // chained on a 16-bit x
            emit(op_out, 4'h0, 8'(rand_bits(8)));
        end
        run_program("alu_random");
        for (int i = 0; i < 4; i++) begin
            emit(op_in, 4'h0, 8'(rand_bits(8)));
            emit(op_out, 4'h0, 8'(rand_bits(8)));   // echo of the read word
        end
        run_program("in_echo");
        for (int i = 0; i < 6; i++) begin
            emit(op_ldx, 4'h0, 8'(rand_bits(8)));
            emit(op_ldy, 4'h0, 8'(rand_bits(8)));
            emit(op_alu, 4'h0, 8'(rand_bits(6)));
            emit(op_jmp, 4'(rand_bits(4)), 8'(prog.size() + 2));   // skips the first out
            emit(op_out, 4'h0, 8'(8'h10 + i));
            emit(op_out, 4'h0, 8'(8'h20 + i));
        end
        run_program("jmp_cond");
        build_random(20);
        run_program("random_a");
        build_random(32);
        run_program("random_b");
        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule
`default_nettype wire

//--- cpu_core.f
hdl/cpu_pkg.sv
hdl/microcode_sequencer.sv
hdl/control_decode.sv
hdl/alu.sv
hdl/datapath.sv
hdl/apb_device_port.sv
hdl/cpu_core.sv
test/cpu_core_tb.sv
